// File: rtl/lzc_regs_pkg.sv
// Register map and shared types of the LZ77 register subsystem; offsets are local word addresses
package lzc_regs_pkg;

   localparam int LOCL_ADDR_W = 8;
   localparam int DATA_W      = 32;

   localparam logic [7:0] REVID = 8'h01;

   localparam logic [LOCL_ADDR_W-1:0] REG_REVID              = 8'h00;
   localparam logic [LOCL_ADDR_W-1:0] REG_COMPRESSION_CFG    = 8'h01;
   localparam logic [LOCL_ADDR_W-1:0] REG_TLV_PARSE_ACTION   = 8'h02;
   localparam logic [LOCL_ADDR_W-1:0] REG_POWER_CREDIT_BURST = 8'h03;
   localparam logic [LOCL_ADDR_W-1:0] REG_SPARE              = 8'h04;
   localparam logic [LOCL_ADDR_W-1:0] REG_DEBUG_STATUS       = 8'h05;
   localparam logic [LOCL_ADDR_W-1:0] REG_IA_CONFIG          = 8'h06;
   localparam logic [LOCL_ADDR_W-1:0] REG_IA_STATUS          = 8'h07;
   localparam logic [LOCL_ADDR_W-1:0] REG_IA_RDATA0          = 8'h08;
   localparam logic [LOCL_ADDR_W-1:0] REG_IA_RDATA1          = 8'h09;
   localparam logic [LOCL_ADDR_W-1:0] REG_IM_STATUS          = 8'h0A;
   localparam logic [LOCL_ADDR_W-1:0] REG_IM_CONFIG          = 8'h0B;

   typedef enum logic [3:0] {
      IA_NOP  = 4'd0,
      IA_READ = 4'd1   // everything else is illegal
   } ia_op_e;

   typedef enum logic [2:0] {
      IA_OK       = 3'd0,
      IA_BAD_ADDR = 3'd1,
      IA_BAD_OP   = 3'd2
   } ia_code_e;

   typedef union packed {
      logic [DATA_W-1:0] raw;
      struct packed {
         ia_op_e      op;    // 31:28
         logic [19:0] rsvd;
         logic [7:0]  addr;  // 7:0
      } f;
   } ia_config_u;

   typedef struct packed {
      logic       tlast;
      logic [3:0] tstrb;
      logic       tid;
      logic [7:0] tuser;
   } cap_meta_t;

   typedef struct packed {
      ia_code_e   code;
      logic [1:0] datawords;  // always 2
      logic [7:0] addr;
   } ia_status_t;

endpackage

// File: rtl/lzc_reg_if.sv
// Local register access; strobes are single-cycle pulses answered by exactly one ack one cycle later
`timescale 1ns/1ps

interface lzc_reg_if;

   logic [lzc_regs_pkg::LOCL_ADDR_W-1:0] addr;
   logic                                 wr_strb;
   logic [lzc_regs_pkg::DATA_W-1:0]      wr_data;
   logic                                 rd_strb;
   logic [lzc_regs_pkg::DATA_W-1:0]      rd_data;
   logic                                 ack;
   logic                                 err_ack;

   modport node (
      output addr, wr_strb, wr_data, rd_strb,
      input  rd_data, ack, err_ack
   );

   modport csr (
      input  addr, wr_strb, wr_data, rd_strb,
      output rd_data, ack, err_ack
   );

endinterface

// File: rtl/lzc_ia_if.sv
// Indirect access to the capture buffer; one command at a time, results held until the next one
`timescale 1ns/1ps

interface lzc_ia_if;

   logic                            cmd_stb;
   lzc_regs_pkg::ia_config_u        cmd;
   logic                            im_mode;    // 1 wrap, 0 stop
   logic                            clear_ovf;
   lzc_regs_pkg::ia_status_t        status;
   logic [lzc_regs_pkg::DATA_W-1:0] rdata0;
   logic [lzc_regs_pkg::DATA_W-1:0] rdata1;
   logic [lzc_regs_pkg::DATA_W-1:0] im_status_word;

   modport csr (
      output cmd_stb, cmd, im_mode, clear_ovf,
      input  status, rdata0, rdata1, im_status_word
   );

   modport mon (
      input  cmd_stb, cmd, im_mode, clear_ovf,
      output status, rdata0, rdata1, im_status_word
   );

endinterface

// File: rtl/lzc_ring_node.sv
// Ring node; RING_ADDR_W >= 8, window requests get no new request until answered, local response wins a tie
`timescale 1ns/1ps

module lzc_ring_node #(
   parameter int RING_ADDR_W = 16
) (
   input  logic                            clk,
   input  logic                            reset_i,
   input  logic [RING_ADDR_W-1:0]          cfg_start_addr_i,
   input  logic [RING_ADDR_W-1:0]          cfg_end_addr_i,
   input  logic [RING_ADDR_W-1:0]          rbus_addr_i,
   input  logic                            rbus_wr_strb_i,
   input  logic [lzc_regs_pkg::DATA_W-1:0] rbus_wr_data_i,
   input  logic                            rbus_rd_strb_i,
   input  logic [lzc_regs_pkg::DATA_W-1:0] rbus_rd_data_i,
   input  logic                            rbus_ack_i,
   input  logic                            rbus_err_ack_i,
   output logic [RING_ADDR_W-1:0]          rbus_addr_o,
   output logic                            rbus_wr_strb_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] rbus_wr_data_o,
   output logic                            rbus_rd_strb_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] rbus_rd_data_o,
   output logic                            rbus_ack_o,
   output logic                            rbus_err_ack_o,
   lzc_reg_if.node                         locl
);

   logic                   in_window;
   logic                   hit;
   logic                   locl_resp;
   logic                   pending;
   logic [RING_ADDR_W-1:0] offset;

   assign in_window = (rbus_addr_i >= cfg_start_addr_i) && (rbus_addr_i <= cfg_end_addr_i);
   assign hit       = in_window && (rbus_wr_strb_i || rbus_rd_strb_i);
   assign offset    = rbus_addr_i - cfg_start_addr_i;
   assign locl_resp = locl.ack || locl.err_ack;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         rbus_wr_strb_o <= 1'b0;
         rbus_rd_strb_o <= 1'b0;
         rbus_ack_o     <= 1'b0;
         rbus_err_ack_o <= 1'b0;
         locl.wr_strb   <= 1'b0;
         locl.rd_strb   <= 1'b0;
         pending        <= 1'b0;
      end else begin
         rbus_wr_strb_o <= rbus_wr_strb_i && !hit;  // consumed requests leave no strobe
         rbus_rd_strb_o <= rbus_rd_strb_i && !hit;
         locl.wr_strb   <= rbus_wr_strb_i && hit;
         locl.rd_strb   <= rbus_rd_strb_i && hit;
         rbus_ack_o     <= locl_resp ? locl.ack : rbus_ack_i;
         rbus_err_ack_o <= locl_resp ? locl.err_ack : rbus_err_ack_i;
         if (hit) begin
            pending <= 1'b1;
         end else if (locl_resp) begin
            pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      rbus_addr_o    <= rbus_addr_i;
      rbus_wr_data_o <= rbus_wr_data_i;
      rbus_rd_data_o <= locl_resp ? locl.rd_data : rbus_rd_data_i;
      if (hit) begin
         locl.addr    <= offset[lzc_regs_pkg::LOCL_ADDR_W-1:0];  // window-relative offset
         locl.wr_data <= rbus_wr_data_i;
      end
   end

   // CSR answers only what this node issued
   a_ack_outstanding : assert property (@(posedge clk) disable iff (reset_i)
      locl_resp |-> pending);

endmodule

// File: rtl/lzc_csr_file.sv
// CSR file; all writable registers clear on reset, IM_CONFIG bit 0 selects wrap mode, bit 1 drops wrapped
`timescale 1ns/1ps

module lzc_csr_file (
   input  logic                            clk,
   input  logic                            reset_i,
   lzc_reg_if.csr                          regs,
   lzc_ia_if.csr                           ia,
   input  logic [lzc_regs_pkg::DATA_W-1:0] debug_status_i,
   output logic [lzc_regs_pkg::DATA_W-1:0] compression_cfg_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] tlv_parse_action_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] power_credit_burst_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] spare_o,
   output logic                            debug_status_read_o
);

   logic [lzc_regs_pkg::DATA_W-1:0] im_cfg_q;
   logic [lzc_regs_pkg::DATA_W-1:0] rd_word;
   logic                            mapped;
   logic                            writable;

   assign writable = regs.addr inside {lzc_regs_pkg::REG_COMPRESSION_CFG,
                                       lzc_regs_pkg::REG_TLV_PARSE_ACTION,
                                       lzc_regs_pkg::REG_POWER_CREDIT_BURST,
                                       lzc_regs_pkg::REG_SPARE,
                                       lzc_regs_pkg::REG_IA_CONFIG,
                                       lzc_regs_pkg::REG_IM_CONFIG};
   assign ia.im_mode = im_cfg_q[0];

   always_comb begin
      rd_word = '0;
      mapped  = 1'b1;
      case (regs.addr)
         lzc_regs_pkg::REG_REVID:              rd_word = 32'(lzc_regs_pkg::REVID);
         lzc_regs_pkg::REG_COMPRESSION_CFG:    rd_word = compression_cfg_o;
         lzc_regs_pkg::REG_TLV_PARSE_ACTION:   rd_word = tlv_parse_action_o;
         lzc_regs_pkg::REG_POWER_CREDIT_BURST: rd_word = power_credit_burst_o;
         lzc_regs_pkg::REG_SPARE:              rd_word = spare_o;
         lzc_regs_pkg::REG_DEBUG_STATUS:       rd_word = debug_status_i;
         lzc_regs_pkg::REG_IA_CONFIG:          rd_word = ia.cmd.raw;
         lzc_regs_pkg::REG_IA_STATUS:          rd_word = 32'(ia.status);
         lzc_regs_pkg::REG_IA_RDATA0:          rd_word = ia.rdata0;
         lzc_regs_pkg::REG_IA_RDATA1:          rd_word = ia.rdata1;
         lzc_regs_pkg::REG_IM_STATUS:          rd_word = ia.im_status_word;
         lzc_regs_pkg::REG_IM_CONFIG:          rd_word = im_cfg_q;
         default:                              mapped  = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         compression_cfg_o    <= '0;
         tlv_parse_action_o   <= '0;
         power_credit_burst_o <= '0;
         spare_o              <= '0;
         im_cfg_q             <= '0;
         ia.cmd               <= '0;
         ia.cmd_stb           <= 1'b0;
         ia.clear_ovf         <= 1'b0;
         regs.ack             <= 1'b0;
         regs.err_ack         <= 1'b0;
         debug_status_read_o  <= 1'b0;
      end else begin
         regs.ack     <= (regs.wr_strb && writable) || (regs.rd_strb && mapped);
         regs.err_ack <= (regs.wr_strb && !writable) || (regs.rd_strb && !mapped);
         debug_status_read_o <= regs.rd_strb && (regs.addr == lzc_regs_pkg::REG_DEBUG_STATUS);
         ia.cmd_stb   <= regs.wr_strb && (regs.addr == lzc_regs_pkg::REG_IA_CONFIG);
         ia.clear_ovf <= regs.wr_strb && (regs.addr == lzc_regs_pkg::REG_IM_CONFIG)
                         && regs.wr_data[1];
         if (regs.wr_strb) begin
            case (regs.addr)
               lzc_regs_pkg::REG_COMPRESSION_CFG:    compression_cfg_o    <= regs.wr_data;
               lzc_regs_pkg::REG_TLV_PARSE_ACTION:   tlv_parse_action_o   <= regs.wr_data;
               lzc_regs_pkg::REG_POWER_CREDIT_BURST: power_credit_burst_o <= regs.wr_data;
               lzc_regs_pkg::REG_SPARE:              spare_o              <= regs.wr_data;
               lzc_regs_pkg::REG_IA_CONFIG:          ia.cmd.raw           <= regs.wr_data;
               lzc_regs_pkg::REG_IM_CONFIG:          im_cfg_q             <= regs.wr_data;
               default:                              ;  // read-only or unmapped
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (regs.rd_strb) begin
         regs.rd_data <= rd_word;
      end
   end

   a_one_ack : assert property (@(posedge clk) disable iff (reset_i)
      !(regs.ack && regs.err_ack));

endmodule

// File: rtl/lzc_capture_monitor.sv
// Stream capture buffer; N_ENTRIES from 2 to 32, a beat accepted together with im_consumed_i is dropped
`timescale 1ns/1ps

module lzc_capture_monitor #(
   parameter int N_ENTRIES = 16
) (
   input  logic                            clk,
   input  logic                            reset_i,
   lzc_ia_if.mon                           ia,
   input  logic                            tvalid_i,
   output logic                            tready_o,
   input  logic [lzc_regs_pkg::DATA_W-1:0] tdata_i,
   input  logic                            tlast_i,
   input  logic [3:0]                      tstrb_i,
   input  logic                            tid_i,
   input  logic [7:0]                      tuser_i,
   input  logic                            im_consumed_i,
   output logic                            im_available_o
);

   localparam int PTR_W = $clog2(N_ENTRIES);

   logic [lzc_regs_pkg::DATA_W-1:0] data_mem [N_ENTRIES];
   lzc_regs_pkg::cap_meta_t         meta_mem [N_ENTRIES];
   lzc_regs_pkg::cap_meta_t         beat_meta;
   lzc_regs_pkg::ia_status_t        next_status;
   logic [PTR_W-1:0]                wr_ptr;
   logic [PTR_W:0]                  count;
   logic [PTR_W-1:0]                rd_idx;
   logic                            wrapped;
   logic                            overflow;
   logic                            full;
   logic                            accept;
   logic                            rd_ok;

   assign full           = (int'(count) == N_ENTRIES);
   assign tready_o       = ia.im_mode || !full;  // wrap mode never stalls
   assign accept         = tvalid_i && tready_o;
   assign im_available_o = (count != '0);
   assign beat_meta      = '{tlast: tlast_i, tstrb: tstrb_i, tid: tid_i, tuser: tuser_i};
   assign ia.im_status_word = {22'd0, overflow, wrapped, 3'd0, 5'(wr_ptr)};

   assign rd_ok  = int'(ia.cmd.f.addr) < N_ENTRIES;
   assign rd_idx = ia.cmd.f.addr[PTR_W-1:0];

   always_ff @(posedge clk) begin
      if (accept) begin
         data_mem[wr_ptr] <= tdata_i;
         meta_mem[wr_ptr] <= beat_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i || im_consumed_i) begin
         wr_ptr   <= '0;
         count    <= '0;
         wrapped  <= 1'b0;
         overflow <= 1'b0;
      end else begin
         if (accept) begin
            wr_ptr <= (int'(wr_ptr) == N_ENTRIES - 1) ? '0 : wr_ptr + 1'b1;
            if (int'(wr_ptr) == N_ENTRIES - 1) begin
               wrapped <= 1'b1;
            end
            if (!full) begin
               count <= count + 1'b1;  // saturates in wrap mode
            end
         end
         if (tvalid_i && !tready_o) begin
            overflow <= 1'b1;  // sticky until consumed
         end
         if (ia.clear_ovf) begin
            wrapped <= 1'b0;
         end
      end
   end

   always_comb begin
      next_status.datawords = 2'd2;
      next_status.addr      = ia.cmd.f.addr;
      if (ia.cmd.f.op == lzc_regs_pkg::IA_READ) begin
         next_status.code = rd_ok ? lzc_regs_pkg::IA_OK : lzc_regs_pkg::IA_BAD_ADDR;
      end else begin
         next_status.code = lzc_regs_pkg::IA_BAD_OP;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ia.status <= '{code: lzc_regs_pkg::IA_OK, datawords: 2'd2, addr: 8'd0};
      end else if (ia.cmd_stb && ia.cmd.f.op != lzc_regs_pkg::IA_NOP) begin
         ia.status <= next_status;
      end
   end

   always_ff @(posedge clk) begin
      if (ia.cmd_stb && ia.cmd.f.op == lzc_regs_pkg::IA_READ && rd_ok) begin
         ia.rdata0 <= data_mem[rd_idx];
         ia.rdata1 <= 32'(meta_mem[rd_idx]);
      end
   end

   a_ptr_range : assert property (@(posedge clk) disable iff (reset_i)
      int'(wr_ptr) < N_ENTRIES);

endmodule

// File: rtl/lzc_regfile_top.sv
// LZ77 register subsystem top; window bounds are ring word addresses and must stay static during traffic
`timescale 1ns/1ps

module lzc_regfile_top #(
   parameter int RING_ADDR_W = 16,
   parameter int N_ENTRIES   = 16
) (
   input  logic                            clk,
   input  logic                            reset_i,
   input  logic [RING_ADDR_W-1:0]          cfg_start_addr_i,
   input  logic [RING_ADDR_W-1:0]          cfg_end_addr_i,
   input  logic [RING_ADDR_W-1:0]          rbus_addr_i,
   input  logic                            rbus_wr_strb_i,
   input  logic [lzc_regs_pkg::DATA_W-1:0] rbus_wr_data_i,
   input  logic                            rbus_rd_strb_i,
   input  logic [lzc_regs_pkg::DATA_W-1:0] rbus_rd_data_i,
   input  logic                            rbus_ack_i,
   input  logic                            rbus_err_ack_i,
   output logic [RING_ADDR_W-1:0]          rbus_addr_o,
   output logic                            rbus_wr_strb_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] rbus_wr_data_o,
   output logic                            rbus_rd_strb_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] rbus_rd_data_o,
   output logic                            rbus_ack_o,
   output logic                            rbus_err_ack_o,
   input  logic [lzc_regs_pkg::DATA_W-1:0] debug_status_i,
   output logic [lzc_regs_pkg::DATA_W-1:0] compression_cfg_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] tlv_parse_action_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] power_credit_burst_o,
   output logic [lzc_regs_pkg::DATA_W-1:0] spare_o,
   output logic                            debug_status_read_o,
   input  logic                            tvalid_i,
   output logic                            tready_o,
   input  logic [lzc_regs_pkg::DATA_W-1:0] tdata_i,
   input  logic                            tlast_i,
   input  logic [3:0]                      tstrb_i,
   input  logic                            tid_i,
   input  logic [7:0]                      tuser_i,
   input  logic                            im_consumed_i,
   output logic                            im_available_o
);

   lzc_reg_if locl_if ();
   lzc_ia_if  ia_if ();

   lzc_ring_node #(
      .RING_ADDR_W (RING_ADDR_W)
   ) u_ring_node (
      .clk, .reset_i, .cfg_start_addr_i, .cfg_end_addr_i,
      .rbus_addr_i, .rbus_wr_strb_i, .rbus_wr_data_i, .rbus_rd_strb_i,
      .rbus_rd_data_i, .rbus_ack_i, .rbus_err_ack_i,
      .rbus_addr_o, .rbus_wr_strb_o, .rbus_wr_data_o, .rbus_rd_strb_o,
      .rbus_rd_data_o, .rbus_ack_o, .rbus_err_ack_o,
      .locl (locl_if.node)
   );

   lzc_csr_file u_csr_file (
      .clk, .reset_i,
      .regs (locl_if.csr),
      .ia   (ia_if.csr),
      .debug_status_i, .compression_cfg_o, .tlv_parse_action_o,
      .power_credit_burst_o, .spare_o, .debug_status_read_o
   );

   lzc_capture_monitor #(
      .N_ENTRIES (N_ENTRIES)
   ) u_capture_monitor (
      .clk, .reset_i,
      .ia (ia_if.mon),
      .tvalid_i, .tready_o, .tdata_i, .tlast_i, .tstrb_i, .tid_i, .tuser_i,
      .im_consumed_i, .im_available_o
   );

endmodule

// File: tb/lzc_regfile_tb.sv
// Testbench for lzc_regfile_top; ring window 0x0100..0x010F, one ring request at a time, fixed seed
`timescale 1ns/1ps

module lzc_regfile_tb;

   localparam int N_ENTRIES  = 16;
   localparam int MAX_CYCLES = 4000;  // ~110 accesses of 6 cycles and 104 stream cycles, wide margin
   localparam logic [15:0] WIN_START = 16'h0100;
   localparam logic [15:0] WIN_END   = 16'h010F;

   logic        clk, reset_i, tvalid_i, tready_o, tlast_i, tid_i, im_consumed_i, im_available_o;
   logic        rbus_wr_strb_i, rbus_rd_strb_i, rbus_ack_i, rbus_err_ack_i, debug_status_read_o;
   logic        rbus_wr_strb_o, rbus_rd_strb_o, rbus_ack_o, rbus_err_ack_o;
   logic [3:0]  tstrb_i;
   logic [7:0]  tuser_i;
   logic [15:0] cfg_start_addr_i, cfg_end_addr_i, rbus_addr_i, rbus_addr_o;
   logic [31:0] rbus_wr_data_i, rbus_rd_data_i, rbus_wr_data_o, rbus_rd_data_o, tdata_i;
   logic [31:0] debug_status_i, compression_cfg_o, tlv_parse_action_o;
   logic [31:0] power_credit_burst_o, spare_o;

   // reference model state
   logic [31:0]              shadow_regs [12];
   logic [31:0]              buf_data [N_ENTRIES];
   lzc_regs_pkg::cap_meta_t  buf_meta [N_ENTRIES];
   lzc_regs_pkg::ia_status_t model_ia_status;
   logic [31:0]              model_rdata0, model_rdata1, lcg_state;
   logic                     model_mode, model_wrapped, model_ovf;
   int                       model_ptr, model_count;
   int                       dbg_pulses  = 0;
   int                       cycle_count = 0;

   lzc_regfile_top #(.RING_ADDR_W(16), .N_ENTRIES(N_ENTRIES)) DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
         stop_on_error($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
      end
   end

   always @(negedge clk) begin
      if (debug_status_read_o) begin
         dbg_pulses++;
      end
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_ack(input string name, input logic got_ack, input logic got_err,
                            input logic exp_ok);
      if (got_ack !== exp_ok || got_err !== !exp_ok) begin
         stop_on_error($sformatf("[FAIL] %0t %s got ack/err_ack %b/%b expected %b/%b",
                                 $time, name, got_ack, got_err, exp_ok, !exp_ok));
      end
   endtask

   task automatic check_ia_status(input string name, input lzc_regs_pkg::ia_status_t got,
                                  input lzc_regs_pkg::ia_status_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("[FAIL] %0t %s got code %0d words %0d addr %0d expected %0d %0d %0d",
                                 $time, name, got.code, got.datawords, got.addr,
                                 exp.code, exp.datawords, exp.addr));
      end
   endtask

   task automatic check_meta(input string name, input lzc_regs_pkg::cap_meta_t got,
                             input lzc_regs_pkg::cap_meta_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic is_writable(input logic [7:0] off);
      return off inside {8'h01, 8'h02, 8'h03, 8'h04, 8'h06, 8'h0B};
   endfunction

   function automatic logic [31:0] ref_reg_read(input logic [7:0] off);
      case (off)
         8'h00:   return {24'd0, 8'h01};  // revision
         8'h05:   return debug_status_i;
         8'h07:   return {19'd0, model_ia_status};
         8'h08:   return model_rdata0;
         8'h09:   return model_rdata1;
         8'h0A:   return {22'd0, model_ovf, model_wrapped, 3'd0, 5'(model_ptr)};
         default: return shadow_regs[off[3:0]];
      endcase
   endfunction

   task automatic apply_write(input logic [7:0] off, input logic [31:0] data);
      int a;
      shadow_regs[off[3:0]] = data;
      a = int'(data[7:0]);
      if (off == 8'h0B) begin
         model_mode = data[0];
         if (data[1]) begin
            model_wrapped = 1'b0;
         end
      end
      if (off == 8'h06 && data[31:28] != 4'd0) begin  // a nop leaves the status alone
         model_ia_status.addr = data[7:0];
         if (data[31:28] != 4'd1) begin
            model_ia_status.code = lzc_regs_pkg::IA_BAD_OP;
         end else if (a >= N_ENTRIES) begin
            model_ia_status.code = lzc_regs_pkg::IA_BAD_ADDR;
         end else begin
            model_ia_status.code = lzc_regs_pkg::IA_OK;
            model_rdata0 = buf_data[a];
            model_rdata1 = {18'd0, buf_meta[a]};
         end
      end
   endtask

   task automatic capture_beat(input logic [31:0] d, input lzc_regs_pkg::cap_meta_t m);
      buf_data[model_ptr] = d;
      buf_meta[model_ptr] = m;
      if (model_ptr == N_ENTRIES - 1) begin
         model_ptr     = 0;
         model_wrapped = 1'b1;
      end else begin
         model_ptr++;
      end
      if (model_count < N_ENTRIES) begin
         model_count++;
      end
   endtask

   task automatic ring_access(input logic [7:0] off, input logic wr, input logic [31:0] wdata,
                              output logic got_ack, output logic got_err, output logic [31:0] rdata);
      int waited;
      @(negedge clk);
      rbus_addr_i    = WIN_START + 16'(off);
      rbus_wr_strb_i = wr;
      rbus_rd_strb_i = !wr;
      rbus_wr_data_i = wdata;
      @(negedge clk);
      rbus_wr_strb_i = 1'b0;
      rbus_rd_strb_i = 1'b0;
      check_flag("rbus_wr_strb_o", rbus_wr_strb_o, 1'b0);  // consumed by the node
      check_flag("rbus_rd_strb_o", rbus_rd_strb_o, 1'b0);
      waited = 0;
      while (!(rbus_ack_o || rbus_err_ack_o) && waited < 10) begin
         @(negedge clk);
         waited++;
      end
      if (!(rbus_ack_o || rbus_err_ack_o)) begin
         stop_on_error($sformatf("no ring response for offset %h within 10 cycles", off));
      end
      got_ack = rbus_ack_o;
      got_err = rbus_err_ack_o;
      rdata   = rbus_rd_data_o;
   endtask

   task automatic reg_write(input logic [7:0] off, input logic [31:0] data);
      logic        a;
      logic        e;
      logic [31:0] rd;
      ring_access(off, 1'b1, data, a, e, rd);
      check_ack($sformatf("write response, offset %h", off), a, e, is_writable(off));
      if (is_writable(off)) begin
         apply_write(off, data);
      end
   endtask

   task automatic reg_read(input logic [7:0] off, output logic [31:0] data);
      logic a;
      logic e;
      ring_access(off, 1'b0, 32'd0, a, e, data);
      check_ack($sformatf("read response, offset %h", off), a, e, off <= 8'h0B);
      if (off <= 8'h0B) begin
         check_word($sformatf("rbus_rd_data_o, offset %h", off), data, ref_reg_read(off));
      end
   endtask

   task automatic check_config_ports();
      check_word("compression_cfg_o", compression_cfg_o, shadow_regs[1]);
      check_word("tlv_parse_action_o", tlv_parse_action_o, shadow_regs[2]);
      check_word("power_credit_burst_o", power_credit_burst_o, shadow_regs[3]);
      check_word("spare_o", spare_o, shadow_regs[4]);
   endtask

   task automatic check_forwarding();
      logic [31:0] d;
      d = next_rand();
      @(negedge clk);
      rbus_addr_i    = WIN_END + 16'd1;  // just above the window
      rbus_wr_strb_i = 1'b1;
      rbus_wr_data_i = d;
      @(negedge clk);
      rbus_wr_strb_i = 1'b0;
      check_word("rbus_addr_o", 32'(rbus_addr_o), 32'(WIN_END + 16'd1));
      check_flag("rbus_wr_strb_o", rbus_wr_strb_o, 1'b1);
      check_flag("rbus_rd_strb_o", rbus_rd_strb_o, 1'b0);
      check_word("rbus_wr_data_o", rbus_wr_data_o, d);
      rbus_addr_i    = WIN_START - 16'd1;  // just below
      rbus_rd_strb_i = 1'b1;
      @(negedge clk);
      rbus_rd_strb_i = 1'b0;
      check_word("rbus_addr_o", 32'(rbus_addr_o), 32'(WIN_START - 16'd1));
      check_flag("rbus_rd_strb_o", rbus_rd_strb_o, 1'b1);
      check_flag("rbus_wr_strb_o", rbus_wr_strb_o, 1'b0);
      d = next_rand();
      rbus_ack_i     = 1'b1;
      rbus_rd_data_i = d;
      @(negedge clk);
      rbus_ack_i     = 1'b0;
      rbus_err_ack_i = 1'b1;
      check_ack("forwarded upstream ack", rbus_ack_o, rbus_err_ack_o, 1'b1);
      check_word("rbus_rd_data_o", rbus_rd_data_o, d);
      @(negedge clk);
      rbus_err_ack_i = 1'b0;
      check_ack("forwarded upstream err_ack", rbus_ack_o, rbus_err_ack_o, 1'b0);
   endtask

   task automatic stream_cycles(input int ncyc);
      logic        pending;
      logic        exp_ready;
      logic [31:0] r;
      pending = 1'b0;
      repeat (ncyc) begin
         @(negedge clk);
         if (!pending) begin
            r       = next_rand();
            pending = (r[31:30] != 2'b00);  // idle about one cycle in four
            tdata_i = next_rand();
            {tlast_i, tstrb_i, tid_i, tuser_i} = r[29:16];
         end
         tvalid_i  = pending;
         exp_ready = model_mode || (model_count < N_ENTRIES);
         check_flag("tready_o", tready_o, exp_ready);
         if (pending && exp_ready) begin
            capture_beat(tdata_i, {tlast_i, tstrb_i, tid_i, tuser_i});
            pending = 1'b0;
         end else if (pending) begin
            model_ovf = 1'b1;  // held back while full
         end
      end
      @(negedge clk);
      tvalid_i = 1'b0;
   endtask

   task automatic consume_buffer();
      @(negedge clk);
      im_consumed_i = 1'b1;
      @(negedge clk);
      im_consumed_i = 1'b0;
      model_ptr     = 0;
      model_count   = 0;
      model_wrapped = 1'b0;
      model_ovf     = 1'b0;
      check_flag("im_available_o", im_available_o, 1'b0);
   endtask

   task automatic read_entry(input int idx);
      logic [31:0] r;
      reg_write(lzc_regs_pkg::REG_IA_CONFIG, {4'h1, 20'h0, 8'(idx)});
      reg_read(lzc_regs_pkg::REG_IA_STATUS, r);
      check_ia_status("REG_IA_STATUS", lzc_regs_pkg::ia_status_t'(r[12:0]), model_ia_status);
      reg_read(lzc_regs_pkg::REG_IA_RDATA0, r);
      reg_read(lzc_regs_pkg::REG_IA_RDATA1, r);
      check_meta("REG_IA_RDATA1 meta", lzc_regs_pkg::cap_meta_t'(r[13:0]), buf_meta[idx]);
   endtask

   initial begin
      logic [31:0]              r;
      lzc_regs_pkg::ia_status_t exp_st;
      lcg_state        = 32'h4689cd38;
      reset_i          = 1'b1;
      cfg_start_addr_i = WIN_START;
      cfg_end_addr_i   = WIN_END;
      rbus_addr_i      = '0;
      rbus_wr_strb_i   = 1'b0;
      rbus_rd_strb_i   = 1'b0;
      rbus_wr_data_i   = '0;
      rbus_rd_data_i   = '0;
      rbus_ack_i       = 1'b0;
      rbus_err_ack_i   = 1'b0;
      tvalid_i         = 1'b0;
      tdata_i          = '0;
      {tlast_i, tstrb_i, tid_i, tuser_i} = '0;
      im_consumed_i    = 1'b0;
      debug_status_i   = next_rand();
      foreach (shadow_regs[i]) shadow_regs[i] = '0;
      model_ia_status  = '{code: lzc_regs_pkg::IA_OK, datawords: 2'd2, addr: 8'd0};
      model_mode       = 1'b0;
      model_ptr        = 0;
      model_count      = 0;
      model_wrapped    = 1'b0;
      model_ovf        = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;
      check_flag("rbus_ack_o", rbus_ack_o, 1'b0);
      check_flag("debug_status_read_o", debug_status_read_o, 1'b0);
      check_flag("tready_o", tready_o, 1'b1);

      for (int off = 1; off <= 4; off++) begin
         reg_write(8'(off), next_rand());
         reg_read(8'(off), r);
      end
      check_config_ports();
      reg_read(lzc_regs_pkg::REG_REVID, r);

      reg_read(8'h0E, r);  // inside the window but unmapped
      reg_write(8'h0E, next_rand());
      reg_write(lzc_regs_pkg::REG_REVID, next_rand());
      reg_write(lzc_regs_pkg::REG_DEBUG_STATUS, next_rand());
      reg_write(lzc_regs_pkg::REG_IM_STATUS, next_rand());
      for (int off = 0; off < 12; off++) begin
         if (is_writable(8'(off))) begin
            reg_read(8'(off), r);
         end
      end
      check_config_ports();
      dbg_pulses = 0;
      reg_read(lzc_regs_pkg::REG_DEBUG_STATUS, r);
      repeat (2) @(negedge clk);
      check_word("debug_status_read_o pulse count", 32'(dbg_pulses), 32'd1);

      check_forwarding();

      reg_write(lzc_regs_pkg::REG_IM_CONFIG, 32'h1);  // wrap mode
      stream_cycles(64);
      if (model_count != N_ENTRIES || !model_wrapped) begin
         stop_on_error("wrap-mode stream did not fill and wrap the capture buffer");
      end
      check_flag("im_available_o", im_available_o, 1'b1);
      reg_read(lzc_regs_pkg::REG_IM_STATUS, r);
      for (int i = 0; i < N_ENTRIES; i++) begin
         read_entry(i);
      end

      reg_write(lzc_regs_pkg::REG_IM_CONFIG, 32'h0);
      consume_buffer();
      stream_cycles(40);
      if (model_count != N_ENTRIES) begin
         stop_on_error("stop-mode stream did not fill the capture buffer");
      end
      check_flag("tready_o", tready_o, 1'b0);
      reg_read(lzc_regs_pkg::REG_IM_STATUS, r);
      check_flag("REG_IM_STATUS overflow", r[9], 1'b1);
      reg_write(lzc_regs_pkg::REG_IM_CONFIG, 32'h3);  // bit 1 drops wrapped but not overflow
      reg_read(lzc_regs_pkg::REG_IM_STATUS, r);
      consume_buffer();
      reg_read(lzc_regs_pkg::REG_IM_STATUS, r);
      check_word("REG_IM_STATUS after consume", r, 32'd0);

      reg_write(lzc_regs_pkg::REG_IA_CONFIG, {4'h1, 20'h0, 8'd20});
      reg_read(lzc_regs_pkg::REG_IA_STATUS, r);
      exp_st = '{code: lzc_regs_pkg::IA_BAD_ADDR, datawords: 2'd2, addr: 8'd20};
      check_ia_status("REG_IA_STATUS bad addr", lzc_regs_pkg::ia_status_t'(r[12:0]), exp_st);
      reg_read(lzc_regs_pkg::REG_IA_RDATA0, r);
      reg_read(lzc_regs_pkg::REG_IA_RDATA1, r);
      reg_write(lzc_regs_pkg::REG_IA_CONFIG, {4'h5, 20'h0, 8'd3});
      reg_read(lzc_regs_pkg::REG_IA_STATUS, r);
      exp_st = '{code: lzc_regs_pkg::IA_BAD_OP, datawords: 2'd2, addr: 8'd3};
      check_ia_status("REG_IA_STATUS bad op", lzc_regs_pkg::ia_status_t'(r[12:0]), exp_st);
      reg_read(lzc_regs_pkg::REG_IA_RDATA0, r);
      reg_read(lzc_regs_pkg::REG_IA_RDATA1, r);

      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: all.f
rtl/lzc_regs_pkg.sv
rtl/lzc_reg_if.sv
rtl/lzc_ia_if.sv
rtl/lzc_ring_node.sv
rtl/lzc_csr_file.sv
rtl/lzc_capture_monitor.sv
rtl/lzc_regfile_top.sv
tb/lzc_regfile_tb.sv

// File: Makefile
# Verilator build and run of the LZ77 register subsystem testbench

TOP = lzc_regfile_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
